// File: logic/boxf_pkg.sv
package boxf_pkg;

    // one grayscale sample.
    typedef logic [7:0] pix_t;

    // sum of the five pixels of one window column, at most 5 * 255.
    typedef logic [10:0] col_sum_t;

    // sum of all 25 window pixels, at most 25 * 255.
    // The threshold offset uses the same width.
    typedef logic [12:0] box_sum_t;

    // column or row position inside a frame.
    typedef logic [9:0] coord_t;

    // frame sequencing of the controller.
    typedef enum logic [2:0] {
        IDLE,
        FILL,
        RUN,
        FLUSH,
        DONE
    } ctrl_state_t;

endpackage

// File: logic/line_buffer.sv
module line_buffer
    import boxf_pkg::*;
#(
    parameter int COLS = 16
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   i_wr,
    input  coord_t i_col,
    input  pix_t   i_pix,
    output pix_t   o_tap0,
    output pix_t   o_tap1,
    output pix_t   o_tap2,
    output pix_t   o_tap3,
    output pix_t   o_tap4
);

    localparam int AW = (COLS > 1) ? $clog2(COLS) : 1;

    // row_mem[0] holds the oldest row, row_mem[3] the row just above the input.
    pix_t row_mem [4][COLS];

    logic [AW-1:0] addr;

    assign addr = i_col[AW-1:0];

    // each write moves the column up by one row and drops the oldest pixel.
    always_ff @(posedge clk) begin
        if (i_wr) begin
            row_mem[0][addr] <= row_mem[1][addr];
            row_mem[1][addr] <= row_mem[2][addr];
            row_mem[2][addr] <= row_mem[3][addr];
            row_mem[3][addr] <= i_pix;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_tap0 <= '0;
            o_tap1 <= '0;
            o_tap2 <= '0;
            o_tap3 <= '0;
            o_tap4 <= '0;
        end else if (i_wr) begin
            o_tap0 <= row_mem[0][addr];
            o_tap1 <= row_mem[1][addr];
            o_tap2 <= row_mem[2][addr];
            o_tap3 <= row_mem[3][addr];
            o_tap4 <= i_pix;
        end
    end

endmodule

// File: logic/window_sum.sv
module window_sum
    import boxf_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     i_adv,
    input  logic     i_ld,
    input  logic     i_sub_en,
    input  pix_t     i_tap0,
    input  pix_t     i_tap1,
    input  pix_t     i_tap2,
    input  pix_t     i_tap3,
    input  pix_t     i_tap4,
    output box_sum_t o_box_sum,
    output pix_t     o_center
);

    pix_t       st1_tap0;
    pix_t       st1_tap1;
    pix_t       st1_tap2;
    pix_t       st1_tap3;
    pix_t       st1_tap4;
    logic [8:0] sum01;
    logic [8:0] sum23;
    pix_t       tap4_d;
    col_sum_t   col_sum;
    col_sum_t   col_dly [5];
    pix_t       center_dly [5];
    box_sum_t   sub_val;
    box_sum_t   acc;

    // stage 1 captures the column taps.
    always_ff @(posedge clk) begin
        if (i_adv) begin
            st1_tap0 <= i_tap0;
            st1_tap1 <= i_tap1;
            st1_tap2 <= i_tap2;
            st1_tap3 <= i_tap3;
            st1_tap4 <= i_tap4;
        end
    end

    // stage 2 adds the pairs while the fifth tap waits a step.
    always_ff @(posedge clk) begin
        if (i_adv) begin
            sum01  <= 9'(st1_tap0) + 9'(st1_tap1);
            sum23  <= 9'(st1_tap2) + 9'(st1_tap3);
            tap4_d <= st1_tap4;
        end
    end

    // stage 3 closes the column sum.
    always_ff @(posedge clk) begin
        if (i_adv) begin
            col_sum <= col_sum_t'(sum01) + col_sum_t'(sum23) + col_sum_t'(tap4_d);
        end
    end

    // column sums of the last five steps; the last entry leaves the window next.
    always_ff @(posedge clk) begin
        if (i_adv) begin
            col_dly[0] <= col_sum;
            for (int i = 1; i < 5; i++) begin
                col_dly[i] <= col_dly[i-1];
            end
        end
    end

    assign sub_val = i_sub_en ? box_sum_t'(col_dly[4]) : '0;

    // running horizontal sum, restarted by ld at the first column of a row.
    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
        end else if (i_adv) begin
            if (i_ld) begin
                acc <= box_sum_t'(col_sum);
            end else begin
                acc <= acc + box_sum_t'(col_sum) - sub_val;
            end
        end
    end

    // the middle row pixel trails its box sum by five steps.
    always_ff @(posedge clk) begin
        if (i_adv) begin
            center_dly[0] <= st1_tap2;
            for (int i = 1; i < 5; i++) begin
                center_dly[i] <= center_dly[i-1];
            end
        end
    end

    assign o_box_sum = acc;
    assign o_center  = center_dly[4];

endmodule

// File: logic/threshold_unit.sv
module threshold_unit
    import boxf_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     i_res_valid,
    input  box_sum_t i_box_sum,
    input  pix_t     i_center,
    input  box_sum_t i_offset,
    output logic     o_valid,
    output box_sum_t o_sum,
    output pix_t     o_center,
    output logic     o_bin
);

    logic [13:0] scaled;
    logic [13:0] limit;

    // 25 * centre as 16 + 8 + 1, compared one bit wider than the sum.
    assign scaled = (14'(i_center) << 4) + (14'(i_center) << 3) + 14'(i_center);
    assign limit  = 14'(i_box_sum) + 14'(i_offset);

    always_ff @(posedge clk) begin
        if (rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_res_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_res_valid) begin
            o_sum    <= i_box_sum;
            o_center <= i_center;
            o_bin    <= scaled > limit;
        end
    end

endmodule

// File: logic/filter_ctrl.sv
module filter_ctrl
    import boxf_pkg::*;
#(
    parameter int COLS = 16,
    parameter int ROWS = 12
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   i_start,
    input  logic   i_pix_valid,
    output logic   o_busy,
    output logic   o_wr,
    output coord_t o_col,
    output logic   o_adv,
    output logic   o_ld,
    output logic   o_sub_en,
    output logic   o_res_valid,
    output logic   o_frame_done
);

    localparam coord_t LAST_COL  = coord_t'(COLS - 1);
    localparam coord_t LAST_ROW  = coord_t'(ROWS - 1);
    localparam coord_t LAST_STEP = coord_t'(COLS + 2);
    // column 0 reaches the accumulator three steps after its taps.
    localparam coord_t LD_STEP   = coord_t'(3);
    localparam coord_t OUT_STEP  = coord_t'(7);
    localparam coord_t SUB_STEP  = coord_t'(8);

    ctrl_state_t state;
    coord_t      row;
    coord_t      step;
    logic [1:0]  seq;
    logic        adv_next;
    logic        interior_q;

    assign o_busy   = (state == FLUSH) || (state == DONE);
    assign o_wr     = i_pix_valid && !o_busy && ((state == FILL) || (state == RUN));
    assign adv_next = (o_wr && (state == RUN)) || (state == FLUSH);

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= IDLE;
            o_col        <= '0;
            row          <= '0;
            seq          <= '0;
            o_frame_done <= 1'b0;
        end else begin
            o_frame_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (i_start) begin
                        state <= FILL;
                        o_col <= '0;
                        row   <= '0;
                        seq   <= '0;
                    end
                end
                FILL, RUN: begin
                    if (o_wr) begin
                        if (o_col == LAST_COL) begin
                            o_col <= '0;
                            row   <= (row == LAST_ROW) ? '0 : row + 1'b1;
                            if (state == RUN) begin
                                state <= FLUSH;
                            end else if (row == coord_t'(3)) begin
                                state <= RUN;
                            end
                        end else begin
                            o_col <= o_col + 1'b1;
                        end
                    end
                end
                FLUSH: begin
                    seq <= seq + 1'b1;
                    if (seq == 2'd2) begin
                        seq   <= '0;
                        // row has wrapped once the last row of the frame is out.
                        state <= (row == '0) ? DONE : RUN;
                    end
                end
                DONE: begin
                    seq <= seq + 1'b1;
                    if (seq == 2'd2) begin
                        seq          <= '0;
                        o_frame_done <= 1'b1;
                        state        <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // the step count tells which column the accumulator takes on each adv.
    always_ff @(posedge clk) begin
        if (rst) begin
            o_adv       <= 1'b0;
            o_ld        <= 1'b0;
            o_sub_en    <= 1'b0;
            interior_q  <= 1'b0;
            o_res_valid <= 1'b0;
            step        <= '0;
        end else begin
            o_adv       <= adv_next;
            o_ld        <= adv_next && (step == LD_STEP);
            o_sub_en    <= adv_next && (step >= SUB_STEP);
            interior_q  <= adv_next && (step >= OUT_STEP);
            o_res_valid <= interior_q;
            if ((state == IDLE) && i_start) begin
                step <= '0;
            end else if (adv_next) begin
                step <= (step == LAST_STEP) ? '0 : step + 1'b1;
            end
        end
    end

endmodule

// File: logic/box_filter_top.sv
module box_filter_top
    import boxf_pkg::*;
#(
    parameter int COLS = 16,
    parameter int ROWS = 12
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     i_start,
    input  logic     i_pix_valid,
    input  pix_t     i_pix,
    input  box_sum_t i_offset,
    output logic     o_busy,
    output logic     o_valid,
    output box_sum_t o_sum,
    output pix_t     o_center,
    output logic     o_bin,
    output logic     o_frame_done
);

    logic     wr;
    coord_t   col;
    logic     adv;
    logic     ld;
    logic     sub_en;
    logic     res_valid;
    pix_t     tap0;
    pix_t     tap1;
    pix_t     tap2;
    pix_t     tap3;
    pix_t     tap4;
    box_sum_t box_sum;
    pix_t     center;

    filter_ctrl #(
        .COLS(COLS),
        .ROWS(ROWS)
    ) u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .i_start     (i_start),
        .i_pix_valid (i_pix_valid),
        .o_busy      (o_busy),
        .o_wr        (wr),
        .o_col       (col),
        .o_adv       (adv),
        .o_ld        (ld),
        .o_sub_en    (sub_en),
        .o_res_valid (res_valid),
        .o_frame_done(o_frame_done)
    );

    line_buffer #(
        .COLS(COLS)
    ) u_line_buffer (
        .clk   (clk),
        .rst   (rst),
        .i_wr  (wr),
        .i_col (col),
        .i_pix (i_pix),
        .o_tap0(tap0),
        .o_tap1(tap1),
        .o_tap2(tap2),
        .o_tap3(tap3),
        .o_tap4(tap4)
    );

    window_sum u_window_sum (
        .clk      (clk),
        .rst      (rst),
        .i_adv    (adv),
        .i_ld     (ld),
        .i_sub_en (sub_en),
        .i_tap0   (tap0),
        .i_tap1   (tap1),
        .i_tap2   (tap2),
        .i_tap3   (tap3),
        .i_tap4   (tap4),
        .o_box_sum(box_sum),
        .o_center (center)
    );

    threshold_unit u_threshold (
        .clk        (clk),
        .rst        (rst),
        .i_res_valid(res_valid),
        .i_box_sum  (box_sum),
        .i_center   (center),
        .i_offset   (i_offset),
        .o_valid    (o_valid),
        .o_sum      (o_sum),
        .o_center   (o_center),
        .o_bin      (o_bin)
    );

endmodule

// File: tests/box_filter_props.sv
module box_filter_props (
    input logic clk,
    input logic rst,
    input logic o_busy,
    input logic o_wr,
    input logic o_adv,
    input logic o_ld,
    input logic o_sub_en,
    input logic o_res_valid,
    input logic o_frame_done
);

    timeunit 1ns;
    timeprecision 100ps;

    // a row flush or the frame tail only begins after the last pixel of a row was taken.
    busy_after_wr: assert property (@(posedge clk) disable iff (rst)
        $rose(o_busy) |-> $past(o_wr))
        else $error("busy raised without a preceding accepted pixel");

    // the accumulator restarts on a pixel step, never on a flush step.
    ld_on_pixel: assert property (@(posedge clk) disable iff (rst)
        o_ld |-> !o_busy)
        else $error("ld issued on a flush step");

    // flush steps always drop the five-old column sum.
    sub_on_flush: assert property (@(posedge clk) disable iff (rst)
        (o_adv && $past(o_busy)) |-> o_sub_en)
        else $error("flush step without sub_en");

    // res_valid reaches o_valid one cycle later, and frame done comes one cycle after that.
    done_after_last: assert property (@(posedge clk) disable iff (rst)
        o_frame_done |-> ($past(o_res_valid, 2) && !$past(o_res_valid, 1) && !o_res_valid))
        else $error("frame done does not follow the final valid");

endmodule

bind filter_ctrl box_filter_props u_props (
    .clk         (clk),
    .rst         (rst),
    .o_busy      (o_busy),
    .o_wr        (o_wr),
    .o_adv       (o_adv),
    .o_ld        (o_ld),
    .o_sub_en    (o_sub_en),
    .o_res_valid (o_res_valid),
    .o_frame_done(o_frame_done)
);

// File: tests/box_filter_tb.sv
module box_filter_tb
    import boxf_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int COLS       = 16;
    localparam int ROWS       = 12;
    localparam int N_RES      = (COLS - 4) * (ROWS - 4);
    localparam int N_FRAMES   = 7;
    localparam int MAX_CYCLES = N_FRAMES * COLS * ROWS * 8 + 2000;

    logic     clk;
    logic     rst;
    logic     i_start;
    logic     i_pix_valid;
    pix_t     i_pix;
    box_sum_t i_offset;
    logic     o_busy;
    logic     o_valid;
    box_sum_t o_sum;
    pix_t     o_center;
    logic     o_bin;
    logic     o_frame_done;

    pix_t     img [ROWS][COLS];
    box_sum_t exp_sum [$];
    pix_t     exp_center [$];
    logic     exp_bin [$];
    string    test_name;
    int       sum_errs   = 0;
    int       pix_errs   = 0;
    int       bit_errs   = 0;
    int       other_errs = 0;
    int       res_cnt    = 0;
    int       bin_cnt    = 0;
    int       done_cnt   = 0;
    int       cycles     = 0;

    box_filter_top #(
        .COLS(COLS),
        .ROWS(ROWS)
    ) DUT (
        .clk         (clk),
        .rst         (rst),
        .i_start     (i_start),
        .i_pix_valid (i_pix_valid),
        .i_pix       (i_pix),
        .i_offset    (i_offset),
        .o_busy      (o_busy),
        .o_valid     (o_valid),
        .o_sum       (o_sum),
        .o_center    (o_center),
        .o_bin       (o_bin),
        .o_frame_done(o_frame_done)
    );

    initial begin
        clk = 1'b0;
    end

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic check_sum(input string name, input box_sum_t exp, input box_sum_t act);
        if (exp !== act) begin
            $display("FAIL %s: sum expected %0d, actual %0d", name, exp, act);
            sum_errs++;
        end
    endtask

    task automatic check_pix(input string name, input pix_t exp, input pix_t act);
        if (exp !== act) begin
            $display("FAIL %s: centre expected %0d, actual %0d", name, exp, act);
            pix_errs++;
        end
    endtask

    task automatic check_bit(input string name, input string what, input logic exp,
                             input logic act);
        if (exp !== act) begin
            $display("FAIL %s: %s expected %b, actual %b", name, what, exp, act);
            bit_errs++;
        end
    endtask

    task automatic check_count(input string name, input string what, input int exp, input int act);
        if (exp != act) begin
            $display("FAIL %s: %s expected %0d, actual %0d", name, what, exp, act);
            other_errs++;
        end
    endtask

    // outputs are registered, so they are settled at the falling edge.
    always @(negedge clk) begin
        if (!rst && o_valid) begin
            res_cnt++;
            if (o_bin) begin
                bin_cnt++;
            end
            if (exp_sum.size() == 0) begin
                $display("%s: a result arrived after all expected results", test_name);
                other_errs++;
            end else begin
                check_sum(test_name, exp_sum.pop_front(), o_sum);
                check_pix(test_name, exp_center.pop_front(), o_center);
                check_bit(test_name, "bin", exp_bin.pop_front(), o_bin);
            end
        end
        if (!rst && o_frame_done) begin
            done_cnt++;
        end
    end

    // interior windows in raster order, bin set when 25 * centre beats sum plus offset.
    task automatic build_expected(input box_sum_t offset);
        int sum;
        int c;
        exp_sum.delete();
        exp_center.delete();
        exp_bin.delete();
        for (int r = 2; r < ROWS - 2; r++) begin
            for (int x = 2; x < COLS - 2; x++) begin
                sum = 0;
                for (int dr = -2; dr <= 2; dr++) begin
                    for (int dc = -2; dc <= 2; dc++) begin
                        sum += int'(img[r + dr][x + dc]);
                    end
                end
                c = int'(img[r][x]);
                exp_sum.push_back(box_sum_t'(sum));
                exp_center.push_back(img[r][x]);
                exp_bin.push_back(25 * c > sum + int'(offset));
            end
        end
    endtask

    task automatic run_frame(input string name, input box_sum_t offset, input bit gaps);
        int waited;
        int done_before;
        test_name = name;
        i_offset = offset;
        build_expected(offset);
        res_cnt = 0;
        bin_cnt = 0;
        done_before = done_cnt;
        @(negedge clk);
        i_start = 1'b1;
        @(negedge clk);
        i_start = 1'b0;
        for (int r = 0; r < ROWS; r++) begin
            for (int x = 0; x < COLS; x++) begin
                if (gaps) begin
                    repeat ($urandom_range(3, 0)) @(negedge clk);
                end
                while (o_busy) begin
                    @(negedge clk);
                end
                i_pix_valid = 1'b1;
                i_pix = img[r][x];
                @(negedge clk);
                i_pix_valid = 1'b0;
                // busy follows only the last pixel of a row past the four fill rows.
                check_bit(name, "busy", (x == COLS - 1) && (r >= 4), o_busy);
            end
        end
        waited = 0;
        while (!o_frame_done && waited < 64) begin
            @(negedge clk);
            waited++;
        end
        if (!o_frame_done) begin
            $display("%s: o_frame_done did not pulse within 64 cycles of the last pixel", name);
            other_errs++;
        end
        @(negedge clk);
        check_bit(name, "busy after frame", 1'b0, o_busy);
        if (exp_sum.size() != 0) begin
            $display("%s: %0d expected results never arrived", name, exp_sum.size());
            other_errs++;
        end
        check_count(name, "result count", N_RES, res_cnt);
        check_count(name, "frame done pulses", 1, done_cnt - done_before);
    endtask

    task automatic flat_image();
        foreach (img[r, x]) begin
            img[r][x] = 8'd100;
        end
        run_frame("flat", '0, 1'b0);
    endtask

    task automatic ramp_image();
        foreach (img[r, x]) begin
            img[r][x] = pix_t'(x + 8 * r);
        end
        run_frame("ramp", '0, 1'b0);
    endtask

    task automatic fill_random();
        foreach (img[r, x]) begin
            img[r][x] = pix_t'($urandom_range(255, 0));
        end
    endtask

    task automatic random_gaps();
        fill_random();
        run_frame("random_gaps", '0, 1'b1);
    endtask

    // a dark level of 10 keeps every flat window exactly at its threshold.
    task automatic bright_pixel();
        foreach (img[r, x]) begin
            img[r][x] = 8'd10;
        end
        img[5][7] = 8'd255;
        run_frame("bright_offset_0", '0, 1'b0);
        check_count("bright_offset_0", "bins set", 1, bin_cnt);
        run_frame("bright_offset_6000", 13'd6000, 1'b0);
        check_count("bright_offset_6000", "bins set", 0, bin_cnt);
    endtask

    task automatic two_frames();
        fill_random();
        run_frame("two_frames_first", 13'd200, 1'b0);
        fill_random();
        run_frame("two_frames_second", '0, 1'b1);
    endtask

    initial begin
        void'($urandom(99389));
        rst = 1'b1;
        i_start = 1'b0;
        i_pix_valid = 1'b0;
        i_pix = '0;
        i_offset = '0;
        test_name = "reset";
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        flat_image();
        ramp_image();
        random_gaps();
        bright_pixel();
        two_frames();
        $display("errors: sum %0d, centre %0d, bit %0d, other %0d",
                 sum_errs, pix_errs, bit_errs, other_errs);
        if (sum_errs + pix_errs + bit_errs + other_errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: vlog.f
logic/boxf_pkg.sv
logic/line_buffer.sv
logic/window_sum.sv
logic/threshold_unit.sv
logic/filter_ctrl.sv
logic/box_filter_top.sv
tests/box_filter_props.sv
tests/box_filter_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= box_filter_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_EXE := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_EXE)

$(SIM_EXE): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_EXE) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST RESULT: FAIL" $(LOG) || \
	   ! grep -q "TEST RESULT: PASS" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
